// ==== logic/lsq_settings.svh ====
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// Store queue, circular
`define LSQ_SQ_CAPACITY 8
`define LSQ_SQ_LEN 3

// Load buffer, any free slot
`define LSQ_LB_CAPACITY 4
`define LSQ_LB_LEN 2

// Datapath and tag widths
`define LSQ_XLEN 32
`define LSQ_PRF_LEN 6
`define LSQ_ROB_LEN 5

`endif

// ==== logic/lsq_pkg.sv ====
`include "lsq_settings.svh"

package lsq_pkg;

    // Byte count is 1 << code
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    ////////////////////
    // Resolve packets

    typedef struct packed {
        logic [`LSQ_LB_LEN-1:0]  slot;
        logic [`LSQ_XLEN-1:0]    base;
        logic [`LSQ_XLEN-1:0]    offset;
        mem_size_t               size;
        logic                    is_signed;
        logic [`LSQ_PRF_LEN-1:0] dest_tag;
        logic [`LSQ_ROB_LEN-1:0] rob_tag;
    } lb_resolve_t;

    typedef struct packed {
        logic [`LSQ_SQ_LEN-1:0]  index;
        logic [`LSQ_XLEN-1:0]    base;
        logic [`LSQ_XLEN-1:0]    offset;
        logic [`LSQ_XLEN-1:0]    data;
        mem_size_t               size;
        logic [`LSQ_ROB_LEN-1:0] rob_tag;
    } sq_resolve_t;

    ////////////////////
    // Queue entries, also the cache request payloads

    typedef struct packed {
        logic                    resolved;
        logic [`LSQ_XLEN-1:0]    addr;
        logic [`LSQ_XLEN-1:0]    data;
        mem_size_t               size;
        logic [`LSQ_ROB_LEN-1:0] rob_tag;
    } sq_entry_t;

    typedef struct packed {
        logic [`LSQ_XLEN-1:0]    addr;
        mem_size_t               size;
        logic                    is_signed;
        logic [`LSQ_PRF_LEN-1:0] dest_tag;
        logic [`LSQ_ROB_LEN-1:0] rob_tag;
        // Store tail when the load was allocated
        logic [`LSQ_SQ_LEN-1:0]  age;
    } lb_entry_t;

    // Forwarded load result for the CDB
    typedef struct packed {
        logic [`LSQ_XLEN-1:0]    value;
        logic [`LSQ_PRF_LEN-1:0] dest_tag;
        logic [`LSQ_ROB_LEN-1:0] rob_tag;
    } cdb_result_t;

endpackage

// ==== logic/sq_pointer_counter.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module sq_pointer_counter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alloc,
    input  logic                   retire,
    output logic [`LSQ_SQ_LEN-1:0] head,
    output logic [`LSQ_SQ_LEN-1:0] tail,
    output logic [`LSQ_SQ_LEN-1:0] count,
    output logic                   full,
    output logic                   empty
);

    function automatic logic [`LSQ_SQ_LEN-1:0] next_ptr(input logic [`LSQ_SQ_LEN-1:0] ptr);
        return (ptr == `LSQ_SQ_LEN'(`LSQ_SQ_CAPACITY - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= next_ptr(tail);
            end
            if (retire) begin
                head <= next_ptr(head);
            end
            // Simultaneous alloc and retire leave the count alone
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (!alloc && retire) begin
                count <= count - 1'b1;
            end
        end
    end

    // One entry kept spare so tail never catches head
    assign full  = (count == `LSQ_SQ_LEN'(`LSQ_SQ_CAPACITY - 1));
    assign empty = (count == '0);

endmodule

// ==== logic/priority_pick.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module priority_pick #(
    parameter int  width     = `LSQ_LB_CAPACITY,
    parameter type payload_t = logic
) (
    input  logic [width-1:0] requests,
    input  payload_t         payloads [width],
    output logic             valid,
    output logic [width-1:0] grant,
    output payload_t         chosen
);

    // Isolate the lowest set request bit
    assign grant = requests & (~requests + 1'b1);
    assign valid = |requests;

    always_comb begin
        chosen = '0;
        for (int i = 0; i < width; i++) begin
            if (grant[i]) begin
                chosen = payloads[i];
            end
        end
    end

endmodule

// ==== logic/store_queue.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module store_queue (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         sq_alloc,
    input  logic                         sq_resolve_valid,
    input  lsq_pkg::sq_resolve_t         sq_resolve,
    input  logic                         store_retire,
    output lsq_pkg::sq_entry_t           entries [`LSQ_SQ_CAPACITY],
    output logic [`LSQ_SQ_CAPACITY-1:0]  occupied,
    output logic [`LSQ_SQ_LEN-1:0]       head,
    output logic [`LSQ_SQ_LEN-1:0]       tail,
    output logic                         sq_full,
    output logic                         sq_head_resolved
);

    logic [`LSQ_SQ_LEN-1:0] count;
    logic                   empty;

    sq_pointer_counter u_sq_pointer_counter (
        .clock  (clock),
        .reset  (reset),
        .alloc  (sq_alloc),
        .retire (store_retire),
        .head   (head),
        .tail   (tail),
        .count  (count),
        .full   (sq_full),
        .empty  (empty)
    );

    ////////////////////
    // Entry writes

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LSQ_SQ_CAPACITY; i++) begin
                entries[i].resolved <= 1'b0;
            end
        end else begin
            if (sq_alloc) begin
                entries[tail].resolved <= 1'b0;
            end
            // A second resolve of the same entry is dropped
            if (sq_resolve_valid && !entries[sq_resolve.index].resolved) begin
                entries[sq_resolve.index].resolved <= 1'b1;
                entries[sq_resolve.index].addr     <= sq_resolve.base + sq_resolve.offset;
                entries[sq_resolve.index].data     <= sq_resolve.data;
                entries[sq_resolve.index].size     <= sq_resolve.size;
                entries[sq_resolve.index].rob_tag  <= sq_resolve.rob_tag;
            end
            if (store_retire) begin
                entries[head].resolved <= 1'b0;
            end
        end
    end

    // Occupied when within count entries of head
    always_comb begin
        for (int i = 0; i < `LSQ_SQ_CAPACITY; i++) begin
            occupied[i] = ((i - int'(head) + `LSQ_SQ_CAPACITY) % `LSQ_SQ_CAPACITY) < int'(count);
        end
    end

    assign sq_head_resolved = !empty && entries[head].resolved;

endmodule

// ==== logic/load_buffer.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module load_buffer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         lb_alloc,
    input  logic [`LSQ_SQ_LEN-1:0]       sq_tail,
    input  logic                         lb_resolve_valid,
    input  lsq_pkg::lb_resolve_t         lb_resolve,
    input  logic [`LSQ_LB_CAPACITY-1:0]  issue_req,
    input  logic [`LSQ_LB_CAPACITY-1:0]  forward_req,
    input  lsq_pkg::cdb_result_t         forward_values [`LSQ_LB_CAPACITY],
    output lsq_pkg::lb_entry_t           entries [`LSQ_LB_CAPACITY],
    output logic [`LSQ_LB_CAPACITY-1:0]  resolved,
    output logic                         lb_full,
    output logic [`LSQ_LB_LEN-1:0]       lb_alloc_idx,
    output logic                         load_request_valid,
    output lsq_pkg::lb_entry_t           load_request,
    output logic                         forward_valid,
    output lsq_pkg::cdb_result_t         forward
);

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAITING,
        SLOT_RESOLVED
    } slot_state_t;

    slot_state_t                 state [`LSQ_LB_CAPACITY];
    logic [`LSQ_LB_CAPACITY-1:0] issue_grant;
    logic [`LSQ_LB_CAPACITY-1:0] forward_grant;

    // Lowest free slot takes the next allocation
    always_comb begin
        lb_full      = 1'b1;
        lb_alloc_idx = '0;
        for (int i = `LSQ_LB_CAPACITY - 1; i >= 0; i--) begin
            if (state[i] == SLOT_FREE) begin
                lb_full      = 1'b0;
                lb_alloc_idx = `LSQ_LB_LEN'(i);
            end
        end
    end

    ////////////////////
    // Slot state

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LSQ_LB_CAPACITY; i++) begin
                state[i] <= SLOT_FREE;
            end
        end else begin
            for (int i = 0; i < `LSQ_LB_CAPACITY; i++) begin
                if (lb_alloc && !lb_full && lb_alloc_idx == `LSQ_LB_LEN'(i)) begin
                    state[i] <= SLOT_WAITING;
                end else if (lb_resolve_valid && lb_resolve.slot == `LSQ_LB_LEN'(i)
                             && state[i] == SLOT_WAITING) begin
                    state[i] <= SLOT_RESOLVED;
                end else if (issue_grant[i] || forward_grant[i]) begin
                    state[i] <= SLOT_FREE;
                end
            end
        end
    end

    // Payload fields
    always_ff @(posedge clock) begin
        if (lb_alloc && !lb_full) begin
            entries[lb_alloc_idx].age <= sq_tail;
        end
        if (lb_resolve_valid && state[lb_resolve.slot] == SLOT_WAITING) begin
            entries[lb_resolve.slot].addr      <= lb_resolve.base + lb_resolve.offset;
            entries[lb_resolve.slot].size      <= lb_resolve.size;
            entries[lb_resolve.slot].is_signed <= lb_resolve.is_signed;
            entries[lb_resolve.slot].dest_tag  <= lb_resolve.dest_tag;
            entries[lb_resolve.slot].rob_tag   <= lb_resolve.rob_tag;
        end
    end

    always_comb begin
        for (int i = 0; i < `LSQ_LB_CAPACITY; i++) begin
            resolved[i] = (state[i] == SLOT_RESOLVED);
        end
    end

    ////////////////////
    // Issue and forward selection

    priority_pick #(
        .width     (`LSQ_LB_CAPACITY),
        .payload_t (lsq_pkg::lb_entry_t)
    ) u_issue_pick (
        .requests (issue_req),
        .payloads (entries),
        .valid    (load_request_valid),
        .grant    (issue_grant),
        .chosen   (load_request)
    );

    priority_pick #(
        .width     (`LSQ_LB_CAPACITY),
        .payload_t (lsq_pkg::cdb_result_t)
    ) u_forward_pick (
        .requests (forward_req),
        .payloads (forward_values),
        .valid    (forward_valid),
        .grant    (forward_grant),
        .chosen   (forward)
    );

endmodule

// ==== logic/dependence_check.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module dependence_check (
    input  lsq_pkg::sq_entry_t           sq_entries [`LSQ_SQ_CAPACITY],
    input  lsq_pkg::lb_entry_t           lb_entries [`LSQ_LB_CAPACITY],
    input  logic [`LSQ_SQ_CAPACITY-1:0]  occupied,
    input  logic [`LSQ_SQ_LEN-1:0]       head,
    input  logic [`LSQ_LB_CAPACITY-1:0]  resolved,
    output logic [`LSQ_LB_CAPACITY-1:0]  issue_req,
    output logic [`LSQ_LB_CAPACITY-1:0]  forward_req,
    output lsq_pkg::cdb_result_t         forward_values [`LSQ_LB_CAPACITY]
);

    // One past the last byte, wide enough not to wrap
    function automatic logic [`LSQ_XLEN:0] end_addr(
        input logic [`LSQ_XLEN-1:0] addr,
        input lsq_pkg::mem_size_t   size
    );
        return {1'b0, addr} + ((`LSQ_XLEN+1)'(1) << size);
    endfunction

    for (genvar j = 0; j < `LSQ_LB_CAPACITY; j++) begin : g_load
        lsq_pkg::lb_entry_t   this_load;
        lsq_pkg::sq_entry_t   hit_store;
        logic [`LSQ_XLEN:0]   load_end;
        logic [`LSQ_XLEN:0]   store_end;
        logic                 blocked;
        logic                 hit;
        logic                 hit_covers;
        int                   load_dist;
        int                   sidx;
        logic [1:0]           byte_off;
        logic [`LSQ_XLEN-1:0] shifted;
        logic [`LSQ_XLEN-1:0] fwd_value;

        assign this_load = lb_entries[j];

        ////////////////////
        // Scan older stores from head, youngest overlap wins
        always_comb begin
            load_dist  = (int'(this_load.age) - int'(head) + `LSQ_SQ_CAPACITY)
                         % `LSQ_SQ_CAPACITY;
            load_end   = end_addr(this_load.addr, this_load.size);
            blocked    = 1'b0;
            hit        = 1'b0;
            hit_covers = 1'b0;
            hit_store  = '0;
            for (int k = 0; k < `LSQ_SQ_CAPACITY; k++) begin
                sidx      = (int'(head) + k) % `LSQ_SQ_CAPACITY;
                store_end = end_addr(sq_entries[sidx].addr, sq_entries[sidx].size);
                if (occupied[sidx] && k < load_dist) begin
                    if (!sq_entries[sidx].resolved) begin
                        blocked = 1'b1;
                    end else if ({1'b0, sq_entries[sidx].addr} < load_end
                                 && {1'b0, this_load.addr} < store_end) begin
                        hit        = 1'b1;
                        hit_store  = sq_entries[sidx];
                        hit_covers = (sq_entries[sidx].addr <= this_load.addr)
                                     && (load_end <= store_end);
                    end
                end
            end
        end

        // Bytes of the store at the load's offset
        assign byte_off = 2'(this_load.addr - hit_store.addr);
        assign shifted  = hit_store.data >> {byte_off, 3'b000};

        always_comb begin
            case (this_load.size)
                lsq_pkg::BYTE: begin
                    fwd_value = {{(`LSQ_XLEN-8){this_load.is_signed & shifted[7]}},
                                 shifted[7:0]};
                end
                lsq_pkg::HALF: begin
                    fwd_value = {{(`LSQ_XLEN-16){this_load.is_signed & shifted[15]}},
                                 shifted[15:0]};
                end
                default: fwd_value = shifted;
            endcase
        end

        // Partial overlap leaves both low until the store retires
        assign issue_req[j]   = resolved[j] && !blocked && !hit;
        assign forward_req[j] = resolved[j] && !blocked && hit && hit_covers;

        assign forward_values[j] = '{
            value:    fwd_value,
            dest_tag: this_load.dest_tag,
            rob_tag:  this_load.rob_tag
        };
    end

endmodule

// ==== logic/load_store_queue.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module load_store_queue (
    input  logic                    clock,
    input  logic                    reset,
    // Load side
    input  logic                    lb_alloc,
    output logic [`LSQ_LB_LEN-1:0]  lb_alloc_idx,
    output logic                    lb_full,
    input  logic                    lb_resolve_valid,
    input  lsq_pkg::lb_resolve_t    lb_resolve,
    // Store side
    input  logic                    sq_alloc,
    output logic [`LSQ_SQ_LEN-1:0]  sq_tail,
    output logic                    sq_full,
    input  logic                    sq_resolve_valid,
    input  lsq_pkg::sq_resolve_t    sq_resolve,
    input  logic                    store_retire,
    output logic                    sq_head_resolved,
    // Data cache
    output logic                    load_request_valid,
    output lsq_pkg::lb_entry_t      load_request,
    output logic                    store_request_valid,
    output lsq_pkg::sq_entry_t      store_request,
    // CDB
    output logic                    forward_valid,
    output lsq_pkg::cdb_result_t    forward
);

    lsq_pkg::sq_entry_t          sq_entries [`LSQ_SQ_CAPACITY];
    logic [`LSQ_SQ_CAPACITY-1:0] sq_occupied;
    logic [`LSQ_SQ_LEN-1:0]      sq_head;
    lsq_pkg::lb_entry_t          lb_entries [`LSQ_LB_CAPACITY];
    logic [`LSQ_LB_CAPACITY-1:0] lb_resolved;
    logic [`LSQ_LB_CAPACITY-1:0] issue_req;
    logic [`LSQ_LB_CAPACITY-1:0] forward_req;
    lsq_pkg::cdb_result_t        forward_values [`LSQ_LB_CAPACITY];

    store_queue u_store_queue (
        .clock            (clock),
        .reset            (reset),
        .sq_alloc         (sq_alloc),
        .sq_resolve_valid (sq_resolve_valid),
        .sq_resolve       (sq_resolve),
        .store_retire     (store_retire),
        .entries          (sq_entries),
        .occupied         (sq_occupied),
        .head             (sq_head),
        .tail             (sq_tail),
        .sq_full          (sq_full),
        .sq_head_resolved (sq_head_resolved)
    );

    // Head store goes to the cache in the retire cycle
    assign store_request_valid = store_retire;
    assign store_request       = sq_entries[sq_head];

    load_buffer u_load_buffer (
        .clock              (clock),
        .reset              (reset),
        .lb_alloc           (lb_alloc),
        .sq_tail            (sq_tail),
        .lb_resolve_valid   (lb_resolve_valid),
        .lb_resolve         (lb_resolve),
        .issue_req          (issue_req),
        .forward_req        (forward_req),
        .forward_values     (forward_values),
        .entries            (lb_entries),
        .resolved           (lb_resolved),
        .lb_full            (lb_full),
        .lb_alloc_idx       (lb_alloc_idx),
        .load_request_valid (load_request_valid),
        .load_request       (load_request),
        .forward_valid      (forward_valid),
        .forward            (forward)
    );

    dependence_check u_dependence_check (
        .sq_entries     (sq_entries),
        .lb_entries     (lb_entries),
        .occupied       (sq_occupied),
        .head           (sq_head),
        .resolved       (lb_resolved),
        .issue_req      (issue_req),
        .forward_req    (forward_req),
        .forward_values (forward_values)
    );

endmodule

// ==== testbench/lsq_checker.sv ====
`timescale 1ns/100ps

module lsq_checker (
    input logic clock,
    input logic reset,
    input logic lb_alloc,
    input logic lb_full,
    input logic sq_alloc,
    input logic sq_full,
    input logic store_request_valid,
    input logic sq_head_resolved,
    input logic load_request_valid,
    input logic forward_valid
);

    // Count of failed properties
    int failures = 0;

    // Only a resolved head store may go to the cache
    a_retire_resolved: assert property (@(posedge clock) disable iff (reset)
        store_request_valid |-> sq_head_resolved)
        else begin
            $error("store request without a resolved head entry");
            failures++;
        end

    ////////////////////
    // No back-pressure, so allocation while full is an input error

    a_lb_alloc_room: assert property (@(posedge clock) disable iff (reset)
        lb_alloc |-> !lb_full)
        else begin
            $error("load allocated while the load buffer is full");
            failures++;
        end

    a_sq_alloc_room: assert property (@(posedge clock) disable iff (reset)
        sq_alloc |-> !sq_full)
        else begin
            $error("store allocated while the store queue is full");
            failures++;
        end

    a_quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !load_request_valid && !forward_valid && !store_request_valid)
        else begin
            $error("valid output high in the cycle after reset");
            failures++;
        end

endmodule

// ==== testbench/lsq_tb.sv ====
`timescale 1ns/100ps
`include "lsq_settings.svh"

module lsq_tb;

    localparam int wait_limit = 50;

    logic                          clock;
    logic                          reset;
    logic                          lb_alloc;
    logic [`LSQ_LB_LEN-1:0]        lb_alloc_idx;
    logic                          lb_full;
    logic                          lb_resolve_valid;
    lsq_pkg::lb_resolve_t          lb_resolve;
    logic                          sq_alloc;
    logic [`LSQ_SQ_LEN-1:0]        sq_tail;
    logic                          sq_full;
    logic                          sq_resolve_valid;
    lsq_pkg::sq_resolve_t          sq_resolve;
    logic                          store_retire;
    logic                          sq_head_resolved;
    logic                          load_request_valid;
    lsq_pkg::lb_entry_t            load_request;
    logic                          store_request_valid;
    lsq_pkg::sq_entry_t            store_request;
    logic                          forward_valid;
    lsq_pkg::cdb_result_t          forward;

    logic [31:0]            rng_state;
    logic [`LSQ_SQ_LEN-1:0] expected_tail;
    int                     errors;
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;

    load_store_queue u_load_store_queue (.*);

    bind load_store_queue lsq_checker u_lsq_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Back to the drive point just after a rising edge
    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("%0t: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic alloc_store(output logic [`LSQ_SQ_LEN-1:0] idx);
        check_value("sq_tail", 32'(expected_tail), 32'(sq_tail));
        idx = sq_tail;
        // Tail wraps at the queue capacity
        expected_tail = `LSQ_SQ_LEN'((int'(expected_tail) + 1) % `LSQ_SQ_CAPACITY);
        sq_alloc = 1'b1;
        tick();
        sq_alloc = 1'b0;
    endtask

    task automatic resolve_store(input logic [`LSQ_SQ_LEN-1:0] idx, input logic [31:0] addr,
                                 input logic [31:0] data, input lsq_pkg::mem_size_t size);
        sq_resolve = '{index: idx, base: addr & ~32'h7, offset: addr & 32'h7, data: data,
                       size: size, rob_tag: 5'(next_random())};
        sq_resolve_valid = 1'b1;
        tick();
        sq_resolve_valid = 1'b0;
    endtask

    task automatic alloc_load(output logic [`LSQ_LB_LEN-1:0] slot);
        slot = lb_alloc_idx;
        lb_alloc = 1'b1;
        tick();
        lb_alloc = 1'b0;
    endtask

    // Allocates a slot and resolves it in the following cycle
    task automatic place_load(input logic [31:0] base, input logic [31:0] offset,
                              input lsq_pkg::mem_size_t size, input logic is_signed,
                              input logic [`LSQ_PRF_LEN-1:0] dest,
                              input logic [`LSQ_ROB_LEN-1:0] rob);
        logic [`LSQ_LB_LEN-1:0] slot;
        alloc_load(slot);
        lb_resolve = '{slot: slot, base: base, offset: offset, size: size,
                       is_signed: is_signed, dest_tag: dest, rob_tag: rob};
        lb_resolve_valid = 1'b1;
        tick();
        lb_resolve_valid = 1'b0;
    endtask

    // Returns at the falling edge where the chosen path shows a request
    task automatic wait_request(input logic forward_path, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < wait_limit && !seen; i++) begin
            @(negedge clock);
            seen = forward_path ? forward_valid : load_request_valid;
        end
        if (!seen) begin
            report_problem(forward_path ? "timeout waiting for forward_valid"
                                        : "timeout waiting for load_request_valid");
        end
    endtask

    task automatic expect_no_request(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            check_value("load_request_valid", 0, load_request_valid);
            check_value("forward_valid", 0, forward_valid);
        end
        tick();
    endtask

    // Head store leaves in the retire cycle
    task automatic retire_store(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        while (!sq_head_resolved && waited < wait_limit) begin
            tick();
            waited++;
        end
        if (!sq_head_resolved) begin
            report_problem("timeout waiting for sq_head_resolved");
        end else begin
            store_retire = 1'b1;
            @(negedge clock);
            check_value("store_request_valid", 1, store_request_valid);
            check_value("store_request.addr", addr, store_request.addr);
            check_value("store_request.data", data, store_request.data);
            tick();
            store_retire = 1'b0;
        end
    endtask

    task automatic forward_check(input logic [31:0] base, input logic [31:0] offset,
                                 input lsq_pkg::mem_size_t size, input logic is_signed,
                                 input logic [31:0] expected);
        logic [`LSQ_PRF_LEN-1:0] dest;
        logic [`LSQ_ROB_LEN-1:0] rob;
        logic                    seen;
        dest = `LSQ_PRF_LEN'(next_random());
        rob  = `LSQ_ROB_LEN'(next_random());
        place_load(base, offset, size, is_signed, dest, rob);
        wait_request(1'b1, seen);
        if (seen) begin
            check_value("forward.value", expected, forward.value);
            check_value("forward.dest_tag", 32'(dest), 32'(forward.dest_tag));
            check_value("forward.rob_tag", 32'(rob), 32'(forward.rob_tag));
            @(negedge clock);
            check_value("forward_valid", 0, forward_valid);
        end
        tick();
    endtask

    ////////////////////
    // Directed tests

    initial begin
        logic [`LSQ_SQ_LEN-1:0] sidx;
        logic [`LSQ_LB_LEN-1:0] lslot;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic                   seen;
        rng_state        = 32'hb5cc4a2e;
        expected_tail    = '0;
        errors           = 0;
        test_errors      = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        reset            = 1'b1;
        lb_alloc         = 1'b0;
        lb_resolve_valid = 1'b0;
        lb_resolve       = '0;
        sq_alloc         = 1'b0;
        sq_resolve_valid = 1'b0;
        sq_resolve       = '0;
        store_retire     = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        @(negedge clock);
        check_value("load_request_valid", 0, load_request_valid);
        check_value("forward_valid", 0, forward_valid);
        check_value("store_request_valid", 0, store_request_valid);
        check_value("lb_full", 0, lb_full);
        check_value("sq_full", 0, sq_full);
        tick();
        finish_test("reset_state");

        // Store queue is empty so nothing is older
        addr = next_random() & ~32'h3;
        place_load(addr, 32'd8, lsq_pkg::WORD, 1'b0, 6'd17, 5'd3);
        wait_request(1'b0, seen);
        if (seen) begin
            check_value("load_request.addr", addr + 32'd8, load_request.addr);
            check_value("load_request.dest_tag", 17, 32'(load_request.dest_tag));
            check_value("load_request.rob_tag", 3, 32'(load_request.rob_tag));
            @(negedge clock);
            check_value("load_request_valid", 0, load_request_valid);
        end
        tick();
        finish_test("load_without_older_store");

        alloc_store(sidx);
        addr = next_random() & ~32'h3;
        place_load(addr, 32'd0, lsq_pkg::WORD, 1'b0, 6'd20, 5'd4);
        check_value("sq_head_resolved", 0, sq_head_resolved);
        expect_no_request(4);
        data = next_random();
        resolve_store(sidx, addr + 32'h100, data, lsq_pkg::WORD);
        wait_request(1'b0, seen);
        if (seen) begin
            check_value("load_request.addr", addr, load_request.addr);
        end
        tick();
        retire_store(addr + 32'h100, data);
        finish_test("load_behind_unresolved_store");

        // Top bit set so the byte load sign-extends with ones
        addr = next_random() & ~32'h3;
        data = next_random() | 32'h8000_0000;
        alloc_store(sidx);
        resolve_store(sidx, addr, data, lsq_pkg::WORD);
        forward_check(addr, 32'd0, lsq_pkg::WORD, 1'b0, data);
        forward_check(addr, 32'd3, lsq_pkg::BYTE, 1'b1, {{24{data[31]}}, data[31:24]});
        forward_check(addr, 32'd2, lsq_pkg::HALF, 1'b0, {16'h0000, data[31:16]});
        retire_store(addr, data);
        finish_test("store_to_load_forward");

        addr = next_random() & ~32'h3;
        data = next_random();
        alloc_store(sidx);
        resolve_store(sidx, addr + 32'd2, data, lsq_pkg::HALF);
        place_load(addr, 32'd0, lsq_pkg::WORD, 1'b0, 6'd30, 5'd9);
        expect_no_request(4);
        retire_store(addr + 32'd2, data);
        wait_request(1'b0, seen);
        if (seen) begin
            check_value("load_request.addr", addr, load_request.addr);
        end
        tick();
        finish_test("partial_overlap_waits");

        addr = next_random() & ~32'h3;
        data = next_random();
        alloc_store(sidx);
        resolve_store(sidx, addr, data, lsq_pkg::WORD);
        retire_store(addr, data);
        for (int i = 1; i <= 7; i++) begin
            alloc_store(sidx);
            check_value("sq_full", 32'(i == 7), sq_full);
        end
        for (int i = 1; i <= 4; i++) begin
            alloc_load(lslot);
            check_value("lb_alloc_idx", 32'(i - 1), 32'(lslot));
            check_value("lb_full", 32'(i == 4), lb_full);
        end
        finish_test("retire_and_full_flags");

        errors += u_load_store_queue.u_lsq_checker.failures;
        $display("tests passed %0d, tests failed %0d, checker failures %0d, errors %0d",
                 tests_passed, tests_failed, u_load_store_queue.u_lsq_checker.failures,
                 errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/lsq_pkg.sv
logic/sq_pointer_counter.sv
logic/priority_pick.sv
logic/store_queue.sv
logic/load_buffer.sv
logic/dependence_check.sv
logic/load_store_queue.sv
testbench/lsq_checker.sv
testbench/lsq_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsq_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) logic/lsq_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
